/* build.f */
+incdir+include
hdl/nice_pkg.sv
hdl/nice_fsm.sv
hdl/beat_counter.sv
hdl/row_buffer.sv
hdl/rowsum_acc.sv
hdl/nice_core.sv
tests/nice_assert.sv
tests/nice_tb.sv

/* hdl/beat_counter.sv */
// beat counters for one row transfer
// issued command count, received response count,
// last-beat flag and command address generation
`include "nice_defines.svh"

module beat_counter (
   input  logic            nice_clk,
   input  logic            nice_rst_n,
   input  logic            start,
   input  nice_pkg::addr_t base,
   input  logic            busy,
   input  logic            cmd_fire,
   input  logic            rsp_fire,
   output nice_pkg::idx_t  cmd_cnt,
   output nice_pkg::idx_t  rsp_cnt,
   output logic            cmd_pending,
   output logic            rsp_last,
   output nice_pkg::addr_t addr
);

   // row start address, captured at acceptance
   nice_pkg::addr_t base_q;

   always_ff @(posedge nice_clk) begin
      if (start) begin
         base_q <= base;
      end
   end

   //////////////////////////////////////////////////
   // counters
   //////////////////////////////////////////////////

   // issue count may run ahead of the response count,
   // the difference is the number of commands in flight
   always_ff @(posedge nice_clk or negedge nice_rst_n) begin
      if (!nice_rst_n) begin
         cmd_cnt <= '0;
         rsp_cnt <= '0;
      end else if (start) begin
         cmd_cnt <= '0;
         rsp_cnt <= '0;
      end else begin
         if (cmd_fire) begin
            cmd_cnt <= cmd_cnt + 1'b1;
         end
         if (rsp_fire) begin
            rsp_cnt <= rsp_cnt + 1'b1;
         end
      end
   end

   // stop issuing once the whole row is out
   assign cmd_pending = busy && (cmd_cnt < `NICE_ROW_LEN);

   // final response of the row
   assign rsp_last = rsp_fire && (rsp_cnt == nice_pkg::idx_t'(`NICE_ROW_LEN - 1));

   //////////////////////////////////////////////////
   // address
   //////////////////////////////////////////////////

   // word k sits at base + k * stride
   assign addr = base_q + nice_pkg::addr_t'(cmd_cnt) * nice_pkg::addr_t'(`NICE_STRIDE);

endmodule

/* hdl/nice_core.sv */
// top level of the row buffer coprocessor
// handshake qualifiers, buffer write steering,
// memory command and core response assembly

module nice_core (
   input  logic                nice_clk,
   input  logic                nice_rst_n,
   input  logic                req_valid,
   output logic                req_ready,
   input  nice_pkg::nice_req_t req,
   output logic                rsp_valid,
   input  logic                rsp_ready,
   output nice_pkg::nice_rsp_t rsp,
   output logic                icb_cmd_valid,
   input  logic                icb_cmd_ready,
   output nice_pkg::icb_cmd_t  icb_cmd,
   input  logic                icb_rsp_valid,
   output logic                icb_rsp_ready,
   input  nice_pkg::icb_rsp_t  icb_rsp,
   output logic                active,
   output logic                mem_holdup
);

   //////////////////////////////////////////////////
   // internal nets
   //////////////////////////////////////////////////

   logic                  start;
   nice_pkg::nice_state_e state;
   nice_pkg::nice_op_e    op;
   logic                  rsp_last;
   logic                  cmd_fire;
   logic                  rsp_fire;
   logic                  cmd_pending;
   nice_pkg::idx_t        cmd_cnt;
   nice_pkg::idx_t        rsp_cnt;
   nice_pkg::addr_t       addr;
   nice_pkg::word_t       rd_data;
   nice_pkg::word_t       sum;
   logic                  err;

   // responses are never back-pressured
   assign icb_rsp_ready = 1'b1;
   assign cmd_fire      = icb_cmd_valid && icb_cmd_ready;
   // beats only count while an operation is running
   assign rsp_fire      = icb_rsp_valid && icb_rsp_ready && mem_holdup;

   nice_fsm u_fsm (
      .nice_clk  (nice_clk),  .nice_rst_n(nice_rst_n),
      .req_valid (req_valid), .req       (req),
      .rsp_ready (rsp_ready), .rsp_last  (rsp_last),
      .req_ready (req_ready), .start     (start),
      .state     (state),     .op        (op),
      .rsp_valid (rsp_valid), .active    (active),
      .mem_holdup(mem_holdup)
   );

   beat_counter u_beat (
      .nice_clk   (nice_clk),    .nice_rst_n(nice_rst_n),
      .start      (start),       .base      (req.rs1),
      .busy       (mem_holdup),  .cmd_fire  (cmd_fire),
      .rsp_fire   (rsp_fire),    .cmd_cnt   (cmd_cnt),
      .rsp_cnt    (rsp_cnt),     .cmd_pending(cmd_pending),
      .rsp_last   (rsp_last),    .addr      (addr)
   );

   // beat k lands in entry k, lbuf overwrites and rowsum adds
   row_buffer u_buf (
      .nice_clk(nice_clk), .nice_rst_n(nice_rst_n),
      .load_we (rsp_fire && (state == nice_pkg::LBUF)),
      .add_we  (rsp_fire && (state == nice_pkg::ROWSUM)),
      .wr_idx  (rsp_cnt),  .wr_data   (icb_rsp.rdata),
      .rd_idx  (cmd_cnt),  .rd_data   (rd_data)
   );

   rowsum_acc u_acc (
      .nice_clk (nice_clk),      .nice_rst_n(nice_rst_n),
      .start    (start),         .beat      (rsp_fire),
      .beat_data(icb_rsp.rdata), .beat_err  (icb_rsp.err),
      .sum      (sum),           .err       (err)
   );

   //////////////////////////////////////////////////
   // bus assembly
   //////////////////////////////////////////////////

   // write only during sbuf, data from the entry being issued
   assign icb_cmd_valid = cmd_pending;
   assign icb_cmd.addr  = addr;
   assign icb_cmd.read  = (state != nice_pkg::SBUF);
   assign icb_cmd.wdata = rd_data;

   // row total is returned for rowsum only
   assign rsp.rdat = (op == nice_pkg::OP_ROWSUM) ? sum : '0;
   assign rsp.err  = err;

endmodule

/* hdl/nice_fsm.sv */
// request decode and operation sequencer
// custom3 field decode, start pulse, latched op kind,
// state register, handshake and status outputs
`include "nice_defines.svh"

module nice_fsm (
   input  logic                  nice_clk,
   input  logic                  nice_rst_n,
   input  logic                  req_valid,
   input  nice_pkg::nice_req_t   req,
   input  logic                  rsp_ready,
   input  logic                  rsp_last,
   output logic                  req_ready,
   output logic                  start,
   output nice_pkg::nice_state_e state,
   output nice_pkg::nice_op_e    op,
   output logic                  rsp_valid,
   output logic                  active,
   output logic                  mem_holdup
);

   //////////////////////////////////////////////////
   // decode
   //////////////////////////////////////////////////

   logic [6:0]         opcode;
   logic [2:0]         func3;
   logic [6:0]         func7;
   logic               is_custom3;
   logic               dec_lbuf;
   logic               dec_sbuf;
   logic               dec_rowsum;
   nice_pkg::nice_op_e dec_op;

   // R-type fields of the offered instruction
   assign opcode = req.inst[6:0];
   assign func3  = req.inst[14:12];
   assign func7  = req.inst[31:25];

   assign is_custom3 = (opcode == `NICE_OPC_CUSTOM3);
   assign dec_lbuf   = is_custom3 && (func3 == `NICE_F3_BUF) && (func7 == `NICE_F7_LBUF);
   assign dec_sbuf   = is_custom3 && (func3 == `NICE_F3_BUF) && (func7 == `NICE_F7_SBUF);
   assign dec_rowsum = is_custom3 && (func3 == `NICE_F3_ROWSUM) && (func7 == `NICE_F7_ROWSUM);

   // op kind of the decoded instruction, only meaningful with start
   assign dec_op = dec_sbuf   ? nice_pkg::OP_SBUF   :
                   dec_rowsum ? nice_pkg::OP_ROWSUM :
                                nice_pkg::OP_LBUF;

   // accepted in idle; anything unsupported is swallowed without start
   assign req_ready = (state == nice_pkg::IDLE);
   assign start     = req_valid && req_ready && (dec_lbuf || dec_sbuf || dec_rowsum);

   //////////////////////////////////////////////////
   // state register
   //////////////////////////////////////////////////

   nice_pkg::nice_state_e state_d;

   always_comb begin
      state_d = state;
      case (state)
         nice_pkg::IDLE: begin
            if (start) begin
               case (dec_op)
                  nice_pkg::OP_SBUF:   state_d = nice_pkg::SBUF;
                  nice_pkg::OP_ROWSUM: state_d = nice_pkg::ROWSUM;
                  default:             state_d = nice_pkg::LBUF;
               endcase
            end
         end
         // memory phase ends with the final response beat
         nice_pkg::LBUF, nice_pkg::SBUF, nice_pkg::ROWSUM: begin
            if (rsp_last) begin
               state_d = nice_pkg::RESP;
            end
         end
         // hold until the core response is taken
         nice_pkg::RESP: begin
            if (rsp_ready) begin
               state_d = nice_pkg::IDLE;
            end
         end
         default: state_d = nice_pkg::IDLE;
      endcase
   end

   always_ff @(posedge nice_clk or negedge nice_rst_n) begin
      if (!nice_rst_n) begin
         state <= nice_pkg::IDLE;
         op    <= nice_pkg::OP_LBUF;
      end else begin
         state <= state_d;
         // op kind stays valid through the response
         if (start) begin
            op <= dec_op;
         end
      end
   end

   //////////////////////////////////////////////////
   // status
   //////////////////////////////////////////////////

   assign rsp_valid  = (state == nice_pkg::RESP);
   assign mem_holdup = (state == nice_pkg::LBUF) || (state == nice_pkg::SBUF) ||
                       (state == nice_pkg::ROWSUM);
   // busy outside idle, or when a request is being offered
   assign active     = (state != nice_pkg::IDLE) || req_valid;

endmodule

/* hdl/nice_pkg.sv */
// shared types of the row buffer coprocessor
// width typedefs, fsm state and op enums,
// request, response and memory bus structs
`include "nice_defines.svh"

package nice_pkg;

   // widths with a meaning
   typedef logic [`NICE_XLEN-1:0] word_t;
   typedef logic [`NICE_XLEN-1:0] addr_t;
   typedef logic [`NICE_IDX_W-1:0] idx_t;

   // sequencer states, one per operation plus idle and response
   typedef enum logic [2:0] {
      IDLE,
      LBUF,
      SBUF,
      ROWSUM,
      RESP
   } nice_state_e;

   // operation kind, latched when the request is taken
   typedef enum logic [1:0] {
      OP_LBUF,
      OP_SBUF,
      OP_ROWSUM
   } nice_op_e;

   // core request: instruction word and rs1
   typedef struct packed {
      word_t inst;
      word_t rs1;
   } nice_req_t;

   // memory command, always a full word
   typedef struct packed {
      addr_t addr;
      logic  read;
      word_t wdata;
   } icb_cmd_t;

   // memory response beat
   typedef struct packed {
      word_t rdata;
      logic  err;
   } icb_rsp_t;

   // core response
   typedef struct packed {
      word_t rdat;
      logic  err;
   } nice_rsp_t;

endpackage

/* hdl/row_buffer.sv */
// row storage of the coprocessor
// word registers with overwrite (lbuf), column add (rowsum)
// and a combinational read port for sbuf write data
`include "nice_defines.svh"

module row_buffer (
   input  logic            nice_clk,
   input  logic            nice_rst_n,
   input  logic            load_we,
   input  logic            add_we,
   input  nice_pkg::idx_t  wr_idx,
   input  nice_pkg::word_t wr_data,
   input  nice_pkg::idx_t  rd_idx,
   output nice_pkg::word_t rd_data
);

   //////////////////////////////////////////////////
   // storage
   //////////////////////////////////////////////////

   nice_pkg::word_t buf_q [`NICE_BUF_DP];
   // entry selected for writing, feeds the column adder
   nice_pkg::word_t wr_old;
   nice_pkg::word_t col_sum;

   assign wr_old  = buf_q[wr_idx];
   // column accumulate wraps like the core adder
   assign col_sum = wr_old + wr_data;

   always_ff @(posedge nice_clk or negedge nice_rst_n) begin
      if (!nice_rst_n) begin
         for (int i = 0; i < `NICE_BUF_DP; i++) begin
            buf_q[i] <= '0;
         end
      end else if (load_we) begin
         // lbuf beat replaces the entry
         buf_q[wr_idx] <= wr_data;
      end else if (add_we) begin
         // rowsum beat adds into the entry
         buf_q[wr_idx] <= col_sum;
      end
   end

   //////////////////////////////////////////////////
   // read port
   //////////////////////////////////////////////////

   // indexed by the issue count during sbuf
   assign rd_data = buf_q[rd_idx];

endmodule

/* hdl/rowsum_acc.sv */
// per-instruction accumulator
// running total of the received words
// and sticky OR of the memory error flags

module rowsum_acc (
   input  logic            nice_clk,
   input  logic            nice_rst_n,
   input  logic            start,
   input  logic            beat,
   input  nice_pkg::word_t beat_data,
   input  logic            beat_err,
   output nice_pkg::word_t sum,
   output logic            err
);

   nice_pkg::word_t sum_d;

   // next total with the current beat folded in
   assign sum_d = sum + beat_data;

   // both values hold after the last beat until the next start,
   // so they stay put while the response waits
   always_ff @(posedge nice_clk or negedge nice_rst_n) begin
      if (!nice_rst_n) begin
         sum <= '0;
         err <= 1'b0;
      end else if (start) begin
         sum <= '0;
         err <= 1'b0;
      end else if (beat) begin
         sum <= sum_d;
         // error is sticky for the whole instruction
         err <= err | beat_err;
      end
   end

   // total wraps modulo 2^XLEN
   // no saturation

endmodule

/* include/nice_defines.svh */
// shared macros for the row buffer coprocessor
// word width, row geometry, address stride
// and the custom3 instruction field codes
`ifndef NICE_DEFINES_SVH
`define NICE_DEFINES_SVH

// data word and byte address width
`define NICE_XLEN 32

// words moved per instruction
`define NICE_ROW_LEN 3
// buffer entries, one spare beyond the row
`define NICE_BUF_DP 4
// width of a buffer index or a beat count
`define NICE_IDX_W 2
// byte step between consecutive words
`define NICE_STRIDE 4

// custom3 R-type opcode and function fields
`define NICE_OPC_CUSTOM3 7'b1111011
`define NICE_F3_BUF 3'b010
`define NICE_F3_ROWSUM 3'b110
`define NICE_F7_LBUF 7'b0000001
`define NICE_F7_SBUF 7'b0000010
`define NICE_F7_ROWSUM 7'b0000110

`endif

/* tests/nice_assert.sv */
// concurrent checks on the coprocessor ports
// shadow row buffer and per-instruction totals built from bus traffic,
// reset values, handshake stability, command and response contents
`include "nice_defines.svh"

module nice_assert (
   input logic                nice_clk,
   input logic                nice_rst_n,
   input logic                req_valid,
   input logic                req_ready,
   input nice_pkg::nice_req_t req,
   input logic                rsp_valid,
   input logic                rsp_ready,
   input nice_pkg::nice_rsp_t rsp,
   input logic                icb_cmd_valid,
   input logic                icb_cmd_ready,
   input nice_pkg::icb_cmd_t  icb_cmd,
   input logic                icb_rsp_valid,
   input logic                icb_rsp_ready,
   input nice_pkg::icb_rsp_t  icb_rsp,
   input logic                active,
   input logic                mem_holdup,
   input nice_pkg::idx_t      cmd_cnt,
   input nice_pkg::idx_t      rsp_cnt
);
   timeunit 1ns;
   timeprecision 100ps;

   int unsigned         fails = 0;
   logic                sup;
   nice_pkg::nice_op_e  req_op;
   logic                sh_busy;
   nice_pkg::nice_op_e  sh_op;
   nice_pkg::addr_t     sh_base;
   int unsigned         sh_issued;
   int unsigned         sh_beats;
   nice_pkg::word_t     sh_sum;
   logic                sh_err;
   nice_pkg::word_t     sh_buf [`NICE_BUF_DP];
   nice_pkg::icb_cmd_t  exp_cmd;
   nice_pkg::nice_rsp_t exp_rsp;

   //////////////////////////////////////////////////
   // reference model
   //////////////////////////////////////////////////

   // kind of the offered instruction, sup low when unsupported
   always_comb begin
      sup    = (req.inst[6:0] == `NICE_OPC_CUSTOM3);
      req_op = nice_pkg::OP_LBUF;
      case ({req.inst[31:25], req.inst[14:12]})
         {`NICE_F7_LBUF, `NICE_F3_BUF}:      req_op = nice_pkg::OP_LBUF;
         {`NICE_F7_SBUF, `NICE_F3_BUF}:      req_op = nice_pkg::OP_SBUF;
         {`NICE_F7_ROWSUM, `NICE_F3_ROWSUM}: req_op = nice_pkg::OP_ROWSUM;
         default:                            sup = 1'b0;
      endcase
   end

   always_ff @(posedge nice_clk or negedge nice_rst_n) begin
      if (!nice_rst_n) begin
         sh_busy   <= 1'b0;
         sh_op     <= nice_pkg::OP_LBUF;
         sh_base   <= '0;
         sh_issued <= 0;
         sh_beats  <= 0;
         sh_sum    <= '0;
         sh_err    <= 1'b0;
         for (int i = 0; i < `NICE_BUF_DP; i++) begin
            sh_buf[i] <= '0;
         end
      end else begin
         // new instruction clears the totals
         if (req_valid && req_ready) begin
            sh_busy   <= sup;
            sh_op     <= req_op;
            sh_base   <= req.rs1;
            sh_issued <= 0;
            sh_beats  <= 0;
            sh_sum    <= '0;
            sh_err    <= 1'b0;
         end
         if (icb_cmd_valid && icb_cmd_ready) begin
            sh_issued <= sh_issued + 1;
         end
         // beat k belongs to word k
         if (icb_rsp_valid && sh_busy) begin
            sh_beats <= sh_beats + 1;
            sh_sum   <= sh_sum + icb_rsp.rdata;
            sh_err   <= sh_err | icb_rsp.err;
            if (sh_op == nice_pkg::OP_LBUF) begin
               sh_buf[sh_beats[1:0]] <= icb_rsp.rdata;
            end else if (sh_op == nice_pkg::OP_ROWSUM) begin
               sh_buf[sh_beats[1:0]] <= sh_buf[sh_beats[1:0]] + icb_rsp.rdata;
            end
         end
         if (rsp_valid && rsp_ready) begin
            sh_busy <= 1'b0;
         end
      end
   end

   // word k at rs1 + 4k with the shadow entry k as write data
   assign exp_cmd.addr  = sh_base + nice_pkg::addr_t'(sh_issued * `NICE_STRIDE);
   assign exp_cmd.read  = (sh_op != nice_pkg::OP_SBUF);
   assign exp_cmd.wdata = sh_buf[sh_issued[1:0]];
   // row total for rowsum only
   assign exp_rsp.rdat  = (sh_op == nice_pkg::OP_ROWSUM) ? sh_sum : '0;
   assign exp_rsp.err   = sh_err;

   //////////////////////////////////////////////////
   // checks
   //////////////////////////////////////////////////

   a_reset: assert property (@(posedge nice_clk) $rose(nice_rst_n) |->
      req_ready && !rsp_valid && !icb_cmd_valid && !active && !mem_holdup &&
      cmd_cnt == '0 && rsp_cnt == '0)
      else begin
         $error("outputs or counts not at their reset values after reset release");
         fails++;
      end

   // a waiting command keeps valid and payload
   a_cmd_hold: assert property (@(posedge nice_clk) disable iff (!nice_rst_n)
      icb_cmd_valid && !icb_cmd_ready |=> icb_cmd_valid && $stable(icb_cmd))
      else begin
         $error("memory command dropped or changed before it was accepted");
         fails++;
      end

   a_rsp_hold: assert property (@(posedge nice_clk) disable iff (!nice_rst_n)
      rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
      else begin
         $error("core response dropped or changed before it was accepted");
         fails++;
      end

   // exactly one row of commands per supported instruction, starting after acceptance
   a_cmd_bound: assert property (@(posedge nice_clk) disable iff (!nice_rst_n)
      icb_cmd_valid == (sh_busy && sh_issued < `NICE_ROW_LEN))
      else begin
         $error("memory command valid does not match a supported instruction with words left");
         fails++;
      end

   a_cmd_data: assert property (@(posedge nice_clk) disable iff (!nice_rst_n)
      icb_cmd_valid && sh_busy |-> icb_cmd == exp_cmd)
      else begin
         $error("Error t=%0t icb_cmd got %h exp %h", $time, $sampled(icb_cmd),
                $sampled(exp_cmd));
         fails++;
      end

   // response right after the third beat and only then
   a_rsp_bound: assert property (@(posedge nice_clk) disable iff (!nice_rst_n)
      rsp_valid == (sh_busy && sh_beats == `NICE_ROW_LEN))
      else begin
         $error("response valid does not match a supported instruction with its three beats");
         fails++;
      end

   a_rsp_data: assert property (@(posedge nice_clk) disable iff (!nice_rst_n)
      rsp_valid |-> rsp == exp_rsp)
      else begin
         $error("Error t=%0t rsp got %h exp %h", $time, $sampled(rsp), $sampled(exp_rsp));
         fails++;
      end

   // unsupported instruction leaves the sequencer in idle
   a_unsup: assert property (@(posedge nice_clk) disable iff (!nice_rst_n)
      req_valid && req_ready && !sup |=> req_ready)
      else begin
         $error("req_ready dropped after an unsupported instruction");
         fails++;
      end

   // status flags follow the instruction lifetime
   // memory responses are never held off
   a_status: assert property (@(posedge nice_clk) disable iff (!nice_rst_n)
      active == (sh_busy || req_valid) &&
      mem_holdup == (sh_busy && sh_beats < `NICE_ROW_LEN) && icb_rsp_ready)
      else begin
         $error("active, mem_holdup or icb_rsp_ready out of step with the instruction");
         fails++;
      end

endmodule

/* tests/nice_tb.sv */
// testbench for the row buffer coprocessor
// clock and reset, memory model with random stalls and delays,
// instruction sequences, timeout and result report
`include "nice_defines.svh"

module nice_tb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int RST_CYCLES  = 10;
   localparam int N_INSTR     = 10;
   // 60 cycles per instruction on top of reset
   localparam int CYCLE_LIMIT = RST_CYCLES + 60 * N_INSTR;

   // R-type encodings with rs2 x0, rs1 x10, rd x11
   localparam logic [31:0] I_LBUF   = {`NICE_F7_LBUF, 5'd0, 5'd10, `NICE_F3_BUF, 5'd11,
                                       `NICE_OPC_CUSTOM3};
   localparam logic [31:0] I_SBUF   = {`NICE_F7_SBUF, 5'd0, 5'd10, `NICE_F3_BUF, 5'd11,
                                       `NICE_OPC_CUSTOM3};
   localparam logic [31:0] I_ROWSUM = {`NICE_F7_ROWSUM, 5'd0, 5'd10, `NICE_F3_ROWSUM, 5'd11,
                                       `NICE_OPC_CUSTOM3};
   // custom3 with an unknown func7, and a plain OP opcode
   localparam logic [31:0] I_BAD_F7  = {7'b1111111, 5'd0, 5'd10, `NICE_F3_BUF, 5'd11,
                                        `NICE_OPC_CUSTOM3};
   localparam logic [31:0] I_BAD_OPC = {`NICE_F7_LBUF, 5'd0, 5'd10, `NICE_F3_BUF, 5'd11,
                                        7'b0110011};

   logic                nice_clk = 1'b0;
   logic                nice_rst_n;
   logic                req_valid;
   logic                req_ready;
   nice_pkg::nice_req_t req;
   logic                rsp_valid;
   logic                rsp_ready;
   nice_pkg::nice_rsp_t rsp;
   logic                icb_cmd_valid;
   logic                icb_cmd_ready;
   nice_pkg::icb_cmd_t  icb_cmd;
   logic                icb_rsp_valid;
   logic                icb_rsp_ready;
   nice_pkg::icb_rsp_t  icb_rsp;
   logic                active;
   logic                mem_holdup;

   nice_pkg::word_t     mem [256];
   nice_pkg::icb_rsp_t  q_rsp [$];
   int unsigned         q_due [$];
   nice_pkg::addr_t     addrs [8];
   int unsigned         cycles = 0;
   int unsigned         n_tests = 0;
   logic [31:0]         lfsr_s = 32'hf4ec7cec;
   // mostly-low ready for the hold test
   logic                heavy;
   // next memory beat carries the error flag
   logic                inject_err;

   always #4 nice_clk = ~nice_clk;

   nice_core dut (.*);

   bind nice_core nice_assert u_chk (.*);

   // x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic take_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_s = lfsr_step(lfsr_s);
         v      = {v[30:0], lfsr_s[0]};
      end
   endtask

   //////////////////////////////////////////////////
   // memory model
   //////////////////////////////////////////////////

   always @(posedge nice_clk) begin : mem_model
      logic               rsp_fire;
      logic               cmd_fire;
      nice_pkg::icb_cmd_t cmd_c;
      nice_pkg::icb_rsp_t beat;
      logic [7:0]         idx;
      logic [31:0]        r;
      // transfers of the edge just taken
      rsp_fire = icb_rsp_valid && icb_rsp_ready;
      cmd_fire = icb_cmd_valid && icb_cmd_ready;
      cmd_c    = icb_cmd;
      #1;
      if (rsp_fire) begin
         void'(q_rsp.pop_front());
         void'(q_due.pop_front());
      end
      // word addressed, reply after 0 to 3 extra cycles
      if (cmd_fire) begin
         take_bits(2, r);
         idx = cmd_c.addr[9:2];
         if (!cmd_c.read) begin
            mem[idx] = cmd_c.wdata;
         end
         beat.rdata = cmd_c.read ? mem[idx] : '0;
         beat.err   = inject_err;
         inject_err = 1'b0;
         q_rsp.push_back(beat);
         q_due.push_back(cycles + r[1:0]);
      end
      icb_rsp_valid = 1'b0;
      icb_rsp       = '0;
      if (q_rsp.size() > 0) begin
         icb_rsp_valid = (cycles >= q_due[0]);
         icb_rsp       = q_rsp[0];
      end
      take_bits(2, r);
      icb_cmd_ready = heavy ? (r[0] & r[1]) : (r[0] | r[1]);
      take_bits(2, r);
      rsp_ready     = heavy ? (r[0] & r[1]) : (r[0] | r[1]);
   end

   // run limit
   always @(posedge nice_clk) begin
      cycles++;
      if (cycles > CYCLE_LIMIT) begin
         $display("timeout after %0d cycles with an instruction still running", CYCLE_LIMIT);
         $display("TEST RESULT: FAIL");
         $finish;
      end
   end

   //////////////////////////////////////////////////
   // stimulus
   //////////////////////////////////////////////////

   // offer one instruction, wait for its response when one is due
   task automatic run_instr(input logic [31:0] inst, input nice_pkg::addr_t rs1,
                            input logic reply);
      req_valid = 1'b1;
      req.inst  = inst;
      req.rs1   = rs1;
      do @(posedge nice_clk); while (!req_ready);
      #1;
      req_valid = 1'b0;
      if (reply) begin
         do @(posedge nice_clk); while (!(rsp_valid && rsp_ready));
      end else begin
         // no response may follow, give it a few cycles to show up
         repeat (4) @(posedge nice_clk);
      end
      #1;
   endtask

   task automatic report_test(input string name);
      n_tests++;
      $display("test %0d %s done at %0t, assertion failures so far %0d", n_tests, name,
               $time, dut.u_chk.fails);
   endtask

   initial begin
      logic [31:0] r;
      for (int i = 0; i < 256; i++) begin
         mem[i] = (32'(i) * 32'h0101_0101) ^ 32'h5a3c_0f81;
      end
      // aligned row addresses, drawn before the memory model runs
      for (int k = 0; k < 8; k++) begin
         take_bits(30, r);
         addrs[k] = {r[29:0], 2'b00};
      end
      nice_rst_n    = 1'b0;
      req_valid     = 1'b0;
      req           = '0;
      rsp_ready     = 1'b0;
      icb_cmd_ready = 1'b0;
      icb_rsp_valid = 1'b0;
      icb_rsp       = '0;
      heavy         = 1'b0;
      inject_err    = 1'b0;
      repeat (RST_CYCLES) @(posedge nice_clk);
      #1;
      nice_rst_n = 1'b1;
      @(posedge nice_clk);
      #1;
      report_test("reset");
      run_instr(I_LBUF, addrs[0], 1'b1);
      run_instr(I_SBUF, addrs[1], 1'b1);
      report_test("lbuf_sbuf");
      run_instr(I_ROWSUM, addrs[2], 1'b1);
      run_instr(I_SBUF, addrs[3], 1'b1);
      report_test("rowsum_sbuf");
      inject_err = 1'b1;
      run_instr(I_ROWSUM, addrs[4], 1'b1);
      run_instr(I_LBUF, addrs[5], 1'b1);
      report_test("error_flag");
      run_instr(I_BAD_F7, addrs[6], 1'b0);
      run_instr(I_BAD_OPC, addrs[6], 1'b0);
      report_test("unsupported");
      heavy = 1'b1;
      run_instr(I_LBUF, addrs[6], 1'b1);
      run_instr(I_SBUF, addrs[7], 1'b1);
      report_test("stall_hold");
      $display("tests %0d, instructions %0d, assertion failures %0d", n_tests, N_INSTR,
               dut.u_chk.fails);
      if (dut.u_chk.fails == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule
